/* src/eth_udp_pkg.sv */
package eth_udp_pkg;

    //////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////
    typedef logic [7:0]  byte_t;      // one gmii byte
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] len_t;       // byte counts
    typedef logic [15:0] csum_t;      // ones complement sum
    typedef logic [31:0] crc_t;       // fcs register

    //////////////////////////////////////////////////
    // protocol constants
    //////////////////////////////////////////////////
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;

    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam byte_t       IP_PROTO_UDP  = 8'd17;
    localparam byte_t       IP_TTL        = 8'd64;

    // dest mac up to end of padding, fcs not counted
    localparam len_t MIN_FRAME_LEN = 16'd60;
    // 14 eth + 20 ip + 8 udp
    localparam len_t HDR_LEN       = 16'd42;

    localparam int IFG_CYCLES = 12;   // idle cycles after each tx frame

endpackage

/* src/udp_rx_parser.sv */
`timescale 1ns/1ps

module udp_rx_parser #(
    parameter eth_udp_pkg::mac_addr_t LOCAL_MAC  = 48'ha0_b1_c2_d3_e1_e1,
    parameter eth_udp_pkg::ip_addr_t  LOCAL_IP   = 32'hC0_A8_01_0B,
    parameter eth_udp_pkg::udp_port_t LOCAL_PORT = 16'h1F90
)(
    input  logic               clk_200m,
    input  logic               rstn,
    input  logic               gmii_rx_dv,
    input  eth_udp_pkg::byte_t gmii_rxd,
    output logic               udp_rec_data_valid,
    output eth_udp_pkg::byte_t udp_rec_rdata,
    output eth_udp_pkg::len_t  udp_rec_data_length
);
    import eth_udp_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_HEADER,
        ST_PAYLOAD,
        ST_DROP
    } rx_state_t;

    rx_state_t   state;
    logic [5:0]  hdr_cnt;      // byte index after the sfd
    len_t        udp_len;      // udp length field as it arrives
    len_t        rem;          // payload bytes still to pass
    byte_t       exp_byte;
    logic        chk;          // this header byte is filtered
    logic        mismatch;
    logic        hdr_ok;       // last header byte, frame accepted

    //////////////////////////////////////////////////
    // expected header bytes
    //////////////////////////////////////////////////
    always_comb
    begin
        chk      = 1'b1;
        exp_byte = '0;
        case (hdr_cnt) inside
            [6'd0:6'd5]:   exp_byte = LOCAL_MAC[8*(6'd5 - hdr_cnt) +: 8];   // dest mac
            [6'd12:6'd13]: exp_byte = ETH_TYPE_IPV4[8*(6'd13 - hdr_cnt) +: 8];
            6'd23:         exp_byte = IP_PROTO_UDP;
            [6'd30:6'd33]: exp_byte = LOCAL_IP[8*(6'd33 - hdr_cnt) +: 8];   // dest ip
            [6'd36:6'd37]: exp_byte = LOCAL_PORT[8*(6'd37 - hdr_cnt) +: 8]; // dest port
            default:       chk = 1'b0;   // src fields, lengths, checksums
        endcase
    end

    assign mismatch = chk && (gmii_rxd != exp_byte);
    // udp_len is complete here, low byte came in at index 39
    assign hdr_ok   = (state == ST_HEADER) && gmii_rx_dv && (hdr_cnt == 6'd41)
                      && !mismatch && (udp_len > 16'd8);

    //////////////////////////////////////////////////
    // frame position fsm
    //////////////////////////////////////////////////
    always_ff @(posedge clk_200m)
    begin
        if (!rstn)
        begin
            state              <= ST_IDLE;
            hdr_cnt            <= '0;
            udp_rec_data_valid <= 1'b0;
        end
        else
        begin
            udp_rec_data_valid <= 1'b0;
            if (!gmii_rx_dv)
                state <= ST_IDLE;      // end of frame, or cut short
            else
            begin
                case (state)
                    ST_IDLE:
                        state <= (gmii_rxd == PREAMBLE_BYTE) ? ST_PREAMBLE : ST_DROP;
                    ST_PREAMBLE:
                    begin
                        hdr_cnt <= '0;
                        if (gmii_rxd == SFD_BYTE)
                            state <= ST_HEADER;
                        else if (gmii_rxd != PREAMBLE_BYTE)
                            state <= ST_DROP;
                    end
                    ST_HEADER:
                    begin
                        hdr_cnt <= hdr_cnt + 6'd1;
                        if (hdr_ok)
                            state <= ST_PAYLOAD;
                        else if (mismatch || hdr_cnt == 6'd41)
                            state <= ST_DROP;   // filter miss or empty datagram
                    end
                    ST_PAYLOAD:
                    begin
                        udp_rec_data_valid <= 1'b1;
                        if (rem == 16'd1)
                            state <= ST_DROP;   // skip pad and fcs
                    end
                    default: ;                  // drop until dv falls
                endcase
            end
        end
    end

    // length capture and payload register
    always_ff @(posedge clk_200m)
    begin
        if (state == ST_HEADER && hdr_cnt == 6'd38)
            udp_len[15:8] <= gmii_rxd;
        if (state == ST_HEADER && hdr_cnt == 6'd39)
            udp_len[7:0] <= gmii_rxd;
        if (hdr_ok)
        begin
            rem                 <= udp_len - 16'd8;
            udp_rec_data_length <= udp_len - 16'd8;   // held until next good frame
        end
        else if (state == ST_PAYLOAD)
            rem <= rem - 16'd1;
        udp_rec_rdata <= gmii_rxd;   // one cycle behind the input
    end

endmodule

/* src/ip_hdr_checksum.sv */
`timescale 1ns/1ps

module ip_hdr_checksum #(
    parameter eth_udp_pkg::ip_addr_t LOCAL_IP = 32'hC0_A8_01_0B,
    parameter eth_udp_pkg::ip_addr_t DEST_IP  = 32'hC0_A8_01_69
)(
    input  logic              clk_200m,
    input  logic              rstn,
    input  logic              ram_w_end,
    input  eth_udp_pkg::len_t tx_length,
    input  logic              tx_busy,
    output logic              hdr_go,
    output eth_udp_pkg::csum_t hdr_csum,
    output eth_udp_pkg::len_t hdr_len
);
    import eth_udp_pkg::*;

    // header words that do not depend on the request
    // 4500, 4000, ttl/proto and both addresses; id and csum are zero
    localparam logic [19:0] FIXED_SUM = 20'h04500 + 20'h04000
                                      + {4'd0, IP_TTL, IP_PROTO_UDP}
                                      + {4'd0, LOCAL_IP[31:16]} + {4'd0, LOCAL_IP[15:0]}
                                      + {4'd0, DEST_IP[31:16]} + {4'd0, DEST_IP[15:0]};

    logic        accept;
    logic        s1_vld;   // partial sum ready
    logic        s2_vld;   // fold ready
    logic [19:0] sum1;
    logic [16:0] fold;

    // new request only when framer and pipe are both free
    assign accept = ram_w_end && !tx_busy && !(s1_vld || s2_vld || hdr_go);

    always_ff @(posedge clk_200m)
    begin
        if (!rstn)
        begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
            hdr_go <= 1'b0;
        end
        else
        begin
            s1_vld <= accept;
            s2_vld <= s1_vld;
            hdr_go <= s2_vld;   // 3 cycles after ram_w_end
        end
    end

    always_ff @(posedge clk_200m)
    begin
        if (accept)
        begin
            hdr_len <= tx_length;
            sum1    <= FIXED_SUM + {4'd0, tx_length + 16'd28};   // + total length
        end
        if (s1_vld)
            fold <= {1'b0, sum1[15:0]} + {13'd0, sum1[19:16]};    // end-around carry
        if (s2_vld)
            hdr_csum <= ~(fold[15:0] + {15'd0, fold[16]});        // last carry, invert
    end

endmodule

/* src/udp_tx_framer.sv */
`timescale 1ns/1ps

module udp_tx_framer #(
    parameter eth_udp_pkg::mac_addr_t DEST_MAC   = 48'h00_0a_35_01_fe_c0,
    parameter eth_udp_pkg::mac_addr_t LOCAL_MAC  = 48'ha0_b1_c2_d3_e1_e1,
    parameter eth_udp_pkg::ip_addr_t  LOCAL_IP   = 32'hC0_A8_01_0B,
    parameter eth_udp_pkg::ip_addr_t  DEST_IP    = 32'hC0_A8_01_69,
    parameter eth_udp_pkg::udp_port_t LOCAL_PORT = 16'h1F90,
    parameter eth_udp_pkg::udp_port_t DEST_PORT  = 16'h1F90
)(
    input  logic               clk_200m,
    input  logic               rstn,
    input  logic               hdr_go,
    input  eth_udp_pkg::csum_t hdr_csum,
    input  eth_udp_pkg::len_t  hdr_len,
    input  logic               data_in_vld,
    input  eth_udp_pkg::byte_t rd_data,
    output logic               start_rd,
    output logic               tx_busy,
    output logic               fr_en,
    output eth_udp_pkg::byte_t fr_data,
    output logic               fr_last
);
    import eth_udp_pkg::*;

    localparam int HDR_BYTES   = 8 + int'(HDR_LEN);   // preamble, sfd and headers
    localparam int TAIL_CYCLES = 5 + IFG_CYCLES;      // last byte, fcs, gap

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEADER,
        ST_WAIT_DATA,
        ST_PAYLOAD,
        ST_PAD,
        ST_TAIL
    } tx_state_t;

    tx_state_t              state;
    logic [5:0]             idx;        // header byte index
    logic [4:0]             tail_cnt;
    len_t                   pay_rem;    // payload bytes still expected
    len_t                   fr_cnt;     // bytes from dest mac on
    len_t                   ip_len;
    len_t                   udp_len;
    logic [8*HDR_BYTES-1:0] hdr_vec;    // whole header, first byte on top

    assign ip_len  = hdr_len + 16'd28;
    assign udp_len = hdr_len + 16'd8;

    //////////////////////////////////////////////////
    // header image
    //////////////////////////////////////////////////
    assign hdr_vec = {
        {7{PREAMBLE_BYTE}}, SFD_BYTE,
        DEST_MAC, LOCAL_MAC, ETH_TYPE_IPV4,
        8'h45, 8'h00, ip_len, 16'h0000,          // ver/ihl, tos, length, id
        16'h4000, IP_TTL, IP_PROTO_UDP,          // dont fragment
        hdr_csum, LOCAL_IP, DEST_IP,
        LOCAL_PORT, DEST_PORT, udp_len, 16'h0000 // udp csum unused
    };

    //////////////////////////////////////////////////
    // framing fsm
    //////////////////////////////////////////////////
    always_ff @(posedge clk_200m)
    begin
        if (!rstn)
        begin
            state    <= ST_IDLE;
            idx      <= '0;
            tail_cnt <= '0;
            tx_busy  <= 1'b0;
            fr_en    <= 1'b0;
            fr_last  <= 1'b0;
            start_rd <= 1'b0;
        end
        else
        begin
            fr_en    <= 1'b0;
            fr_last  <= 1'b0;
            start_rd <= 1'b0;
            case (state)
                ST_IDLE:
                    if (hdr_go)
                    begin
                        tx_busy <= 1'b1;
                        idx     <= '0;
                        state   <= ST_HEADER;
                    end
                ST_HEADER:
                begin
                    fr_en <= 1'b1;
                    idx   <= idx + 6'd1;
                    if (idx == 6'(HDR_BYTES - 1))
                    begin
                        start_rd <= 1'b1;   // same cycle as last header byte
                        state    <= ST_WAIT_DATA;
                    end
                end
                ST_WAIT_DATA, ST_PAYLOAD:
                    if (data_in_vld)
                    begin
                        fr_en <= 1'b1;
                        state <= ST_PAYLOAD;
                        if (pay_rem == 16'd1)
                        begin
                            if (fr_cnt < MIN_FRAME_LEN - 16'd1)
                                state <= ST_PAD;
                            else
                            begin
                                fr_last  <= 1'b1;
                                tail_cnt <= '0;
                                state    <= ST_TAIL;
                            end
                        end
                    end
                ST_PAD:
                begin
                    fr_en <= 1'b1;
                    if (fr_cnt == MIN_FRAME_LEN - 16'd1)
                    begin
                        fr_last  <= 1'b1;
                        tail_cnt <= '0;
                        state    <= ST_TAIL;
                    end
                end
                default:   // tail, hold busy over fcs and gap
                begin
                    tail_cnt <= tail_cnt + 5'd1;
                    if (tail_cnt == 5'(TAIL_CYCLES - 1))
                    begin
                        tx_busy <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // byte path and counters
    always_ff @(posedge clk_200m)
    begin
        case (state)
            ST_IDLE:
                if (hdr_go)
                begin
                    pay_rem <= hdr_len;
                    fr_cnt  <= HDR_LEN;
                end
            ST_HEADER:
                fr_data <= hdr_vec[8*(HDR_BYTES - 1 - int'(idx)) +: 8];
            ST_WAIT_DATA, ST_PAYLOAD:
                if (data_in_vld)
                begin
                    fr_data <= rd_data;   // one cycle behind rd_data
                    pay_rem <= pay_rem - 16'd1;
                    fr_cnt  <= fr_cnt + 16'd1;
                end
            ST_PAD:
            begin
                fr_data <= '0;
                fr_cnt  <= fr_cnt + 16'd1;
            end
            default: ;
        endcase
    end

endmodule

/* src/eth_fcs_append.sv */
`timescale 1ns/1ps

module eth_fcs_append (
    input  logic               clk_200m,
    input  logic               rstn,
    input  logic               fr_en,
    input  eth_udp_pkg::byte_t fr_data,
    input  logic               fr_last,
    output logic               gmii_tx_en,
    output eth_udp_pkg::byte_t gmii_txd
);
    import eth_udp_pkg::*;

    localparam crc_t CRC_POLY_REV = 32'hEDB88320;   // 04C11DB7 bit reversed

    crc_t       crc;
    logic [3:0] pre_cnt;   // preamble and sfd bytes seen
    logic [2:0] fcs_cnt;   // fcs bytes left to send

    // lsb first crc-32, one byte per call
    function automatic crc_t crc_byte(input crc_t crc_in, input byte_t d);
        crc_t c;
        c = crc_in;
        for (int i = 0; i < 8; i++)
        begin
            if (c[0] ^ d[i])
                c = (c >> 1) ^ CRC_POLY_REV;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    //////////////////////////////////////////////////
    // stream delay and fcs insertion
    //////////////////////////////////////////////////
    always_ff @(posedge clk_200m)
    begin
        if (!rstn)
        begin
            gmii_tx_en <= 1'b0;
            crc        <= '1;
            pre_cnt    <= '0;
            fcs_cnt    <= '0;
        end
        else if (fcs_cnt != 3'd0)
        begin
            gmii_tx_en <= 1'b1;
            gmii_txd   <= ~crc[7:0];              // low byte first
            crc        <= {8'hFF, crc[31:8]};     // ends all ones for next frame
            fcs_cnt    <= fcs_cnt - 3'd1;
        end
        else
        begin
            gmii_tx_en <= fr_en;   // payload gap shows through
            gmii_txd   <= fr_data;
            if (fr_en)
            begin
                if (pre_cnt != 4'd8)
                    pre_cnt <= pre_cnt + 4'd1;   // not in the crc
                else
                    crc <= crc_byte(crc, fr_data);
            end
            if (fr_last)
            begin
                fcs_cnt <= 3'd4;
                pre_cnt <= '0;
            end
        end
    end

endmodule

/* src/eth_udp_top.sv */
`timescale 1ns/1ps

module eth_udp_top #(
    parameter eth_udp_pkg::mac_addr_t LOCAL_MAC  = 48'ha0_b1_c2_d3_e1_e1,
    parameter eth_udp_pkg::ip_addr_t  LOCAL_IP   = 32'hC0_A8_01_0B,  // 192.168.1.11
    parameter eth_udp_pkg::udp_port_t LOCAL_PORT = 16'h1F90,
    parameter eth_udp_pkg::mac_addr_t DEST_MAC   = 48'h00_0a_35_01_fe_c0,
    parameter eth_udp_pkg::ip_addr_t  DEST_IP    = 32'hC0_A8_01_69,  // 192.168.1.105
    parameter eth_udp_pkg::udp_port_t DEST_PORT  = 16'h1F90
)(
    input  logic               clk_200m,
    input  logic               rstn,
    // gmii receive
    input  logic               gmii_rx_dv,
    input  eth_udp_pkg::byte_t gmii_rxd,
    // transmit request and payload memory
    input  logic               ram_w_end,
    input  eth_udp_pkg::len_t  tx_length,
    input  logic               data_in_vld,
    input  eth_udp_pkg::byte_t rd_data,
    // received payload
    output logic               udp_rec_data_valid,
    output eth_udp_pkg::byte_t udp_rec_rdata,
    output eth_udp_pkg::len_t  udp_rec_data_length,
    output logic               start_rd,
    // gmii transmit
    output logic               gmii_tx_en,
    output eth_udp_pkg::byte_t gmii_txd
);
    import eth_udp_pkg::*;

    logic  tx_busy;     // framer owns the tx path
    logic  hdr_go;      // checksum ready
    csum_t hdr_csum;
    len_t  hdr_len;
    logic  fr_en;       // framed stream, no fcs yet
    byte_t fr_data;
    logic  fr_last;

    //////////////////////////////////////////////////
    // receive path
    //////////////////////////////////////////////////
    udp_rx_parser #(
        .LOCAL_MAC  (LOCAL_MAC),
        .LOCAL_IP   (LOCAL_IP),
        .LOCAL_PORT (LOCAL_PORT)
    ) u_rx_parser (
        .clk_200m            (clk_200m),
        .rstn                (rstn),
        .gmii_rx_dv          (gmii_rx_dv),
        .gmii_rxd            (gmii_rxd),
        .udp_rec_data_valid  (udp_rec_data_valid),
        .udp_rec_rdata       (udp_rec_rdata),
        .udp_rec_data_length (udp_rec_data_length)
    );

    //////////////////////////////////////////////////
    // transmit path
    //////////////////////////////////////////////////
    ip_hdr_checksum #(
        .LOCAL_IP (LOCAL_IP),
        .DEST_IP  (DEST_IP)
    ) u_hdr_csum (
        .clk_200m  (clk_200m),
        .rstn      (rstn),
        .ram_w_end (ram_w_end),
        .tx_length (tx_length),
        .tx_busy   (tx_busy),
        .hdr_go    (hdr_go),
        .hdr_csum  (hdr_csum),
        .hdr_len   (hdr_len)
    );

    udp_tx_framer #(
        .DEST_MAC   (DEST_MAC),
        .LOCAL_MAC  (LOCAL_MAC),
        .LOCAL_IP   (LOCAL_IP),
        .DEST_IP    (DEST_IP),
        .LOCAL_PORT (LOCAL_PORT),   // source port of the tx datagram
        .DEST_PORT  (DEST_PORT)
    ) u_framer (
        .clk_200m    (clk_200m),
        .rstn        (rstn),
        .hdr_go      (hdr_go),
        .hdr_csum    (hdr_csum),
        .hdr_len     (hdr_len),
        .data_in_vld (data_in_vld),
        .rd_data     (rd_data),
        .start_rd    (start_rd),
        .tx_busy     (tx_busy),
        .fr_en       (fr_en),
        .fr_data     (fr_data),
        .fr_last     (fr_last)
    );

    eth_fcs_append u_fcs (
        .clk_200m   (clk_200m),
        .rstn       (rstn),
        .fr_en      (fr_en),
        .fr_data    (fr_data),
        .fr_last    (fr_last),
        .gmii_tx_en (gmii_tx_en),
        .gmii_txd   (gmii_txd)
    );

endmodule

/* verif/eth_udp_tb.sv */
`timescale 1ns/1ps

module eth_udp_tb;
    import eth_udp_pkg::*;

    localparam mac_addr_t T_LOCAL_MAC  = 48'ha0_b1_c2_d3_e1_e1;
    localparam ip_addr_t  T_LOCAL_IP   = 32'hC0_A8_01_0B;
    localparam udp_port_t T_LOCAL_PORT = 16'h1F90;
    localparam mac_addr_t T_DEST_MAC   = 48'h00_0a_35_01_fe_c0;
    localparam ip_addr_t  T_DEST_IP    = 32'hC0_A8_01_69;
    localparam udp_port_t T_DEST_PORT  = 16'h1F91;

    //////////////////////////////////////////////////
    // case tables
    //////////////////////////////////////////////////
    // rx kind: 0 good, 1 mac, 2 ethertype, 3 proto, 4 ip, 5 port, 6 cut in header
    localparam int N_RX = 9;
    int rx_kind [N_RX] = '{0, 0, 0, 1, 2, 3, 4, 5, 6};
    int rx_len  [N_RX] = '{1, 18, 100, 20, 20, 20, 20, 20, 20};
    bit rx_acc  [N_RX] = '{1, 1, 1, 0, 0, 0, 0, 0, 0};
    localparam int N_TX = 6;
    int tx_len  [N_TX] = '{1, 18, 19, 200, 40, 33};
    bit tx_dup  [N_TX] = '{0, 0, 0, 0, 1, 0};   // second request while busy
    localparam int OV_RX_LEN = 64;              // overlapping rx/tx pair
    localparam int OV_TX_LEN = 300;

    logic  clk_200m;
    logic  rstn;
    logic  gmii_rx_dv;
    byte_t gmii_rxd;
    logic  ram_w_end;
    len_t  tx_length;
    logic  data_in_vld;
    byte_t rd_data;
    logic  udp_rec_data_valid;
    byte_t udp_rec_rdata;
    len_t  udp_rec_data_length;
    logic  start_rd;
    logic  gmii_tx_en;
    byte_t gmii_txd;

    int    cyc = 0;          // posedge count
    int    rx_errs = 0;
    int    tx_errs = 0;
    int    pass_cases = 0;
    int    fail_cases = 0;
    int    start_cnt = 0;
    len_t  rx_exp_len;
    byte_t build_q[$];       // frame under construction
    byte_t rx_exp_byte[$];
    int    rx_exp_cyc[$];    // cycle each payload byte went in
    byte_t tx_payload[$];    // memory model contents
    byte_t tx_exp[$];
    byte_t tx_got[$];

    eth_udp_top #(
        .LOCAL_MAC  (T_LOCAL_MAC),
        .LOCAL_IP   (T_LOCAL_IP),
        .LOCAL_PORT (T_LOCAL_PORT),
        .DEST_MAC   (T_DEST_MAC),
        .DEST_IP    (T_DEST_IP),
        .DEST_PORT  (T_DEST_PORT)
    ) dut0 (.*);

    initial clk_200m = 1'b0;
    always #10 clk_200m = ~clk_200m;
    always @(posedge clk_200m) cyc = cyc + 1;

    // preamble, frame padded to 60, fcs
    function automatic int frame_len(input int p);
        return 12 + ((p + 42 < 60) ? 60 : p + 42);
    endfunction

    // msb first crc on bit reversed input, reflected at the end
    function automatic crc_t fcs_of(input byte_t q[$], input int first);
        crc_t c;
        crc_t r;
        logic fb;
        c = 32'hFFFF_FFFF;
        for (int i = first; i < q.size(); i++)
        begin
            for (int b = 0; b < 8; b++)
            begin
                fb = c[31] ^ q[i][b];
                c  = {c[30:0], 1'b0};
                if (fb)
                    c = c ^ 32'h04C1_1DB7;
            end
        end
        for (int b = 0; b < 32; b++)
            r[b] = c[31 - b];
        return ~r;
    endfunction

    task automatic put_bytes(input logic [47:0] v, input int n);
        for (int i = n - 1; i >= 0; i--)
            build_q.push_back(v[8*i +: 8]);   // network order
    endtask

    // preamble up to the ip ttl field, same for rx and tx
    task automatic put_front(input mac_addr_t dmac, input mac_addr_t smac,
                             input logic [15:0] etype, input int plen);
        build_q = {};
        repeat (7) build_q.push_back(PREAMBLE_BYTE);
        build_q.push_back(SFD_BYTE);
        put_bytes(dmac, 6);
        put_bytes(smac, 6);
        put_bytes(48'(etype), 2);
        put_bytes(48'h4500, 2);
        put_bytes(48'(plen + 28), 2);   // ip total length
        put_bytes(48'h0000_4000, 4);    // id, flags
    endtask

    task automatic pad_and_fcs;
        crc_t f;
        while (build_q.size() < 68)
            build_q.push_back(8'h00);
        f = fcs_of(build_q, 8);
        for (int k = 0; k < 4; k++)
            build_q.push_back(f[8*k +: 8]);   // low byte first
    endtask

    //////////////////////////////////////////////////
    // receive side
    //////////////////////////////////////////////////
    task automatic send_rx(input int idx, input int kind, input int plen, input bit accept);
        byte_t f[$];
        int    errs0;
        errs0 = rx_errs;
        put_front((kind == 1) ? T_LOCAL_MAC ^ 48'h1 : T_LOCAL_MAC, T_DEST_MAC,
                  (kind == 2) ? 16'h86DD : ETH_TYPE_IPV4, plen);
        build_q.push_back(IP_TTL);
        build_q.push_back((kind == 3) ? 8'd6 : IP_PROTO_UDP);   // tcp when wrong
        put_bytes(48'h0, 2);                                     // ip csum unchecked
        put_bytes(48'(T_DEST_IP), 4);
        put_bytes(48'((kind == 4) ? T_LOCAL_IP ^ 32'h1 : T_LOCAL_IP), 4);
        put_bytes(48'(T_DEST_PORT), 2);
        put_bytes(48'((kind == 5) ? T_LOCAL_PORT + 16'd1 : T_LOCAL_PORT), 2);
        put_bytes(48'(plen + 8), 2);
        put_bytes(48'h0, 2);
        for (int i = 0; i < plen; i++)
            build_q.push_back(8'($urandom));
        pad_and_fcs();
        f = build_q;
        if (kind == 6)
        begin
            while (f.size() > 49)
                f.pop_back();   // dv drops before the last udp header byte
        end
        if (accept)
            rx_exp_len = len_t'(plen);
        @(posedge clk_200m);
        #1;
        for (int i = 0; i < f.size(); i++)
        begin
            gmii_rx_dv = 1'b1;
            gmii_rxd   = f[i];
            if (accept && i >= 50 && i < 50 + plen)
            begin
                rx_exp_byte.push_back(f[i]);
                rx_exp_cyc.push_back(cyc);
            end
            @(posedge clk_200m);
            #1;
        end
        gmii_rx_dv = 1'b0;
        gmii_rxd   = '0;
        repeat (3) @(posedge clk_200m);   // last byte is out one cycle later
        if (rx_exp_byte.size() != 0)
        begin
            $display("%0d payload bytes never appeared on udp_rec_rdata at %0t",
                     rx_exp_byte.size(), $time);
            rx_errs++;
        end
        rx_exp_byte = {};
        rx_exp_cyc  = {};
        repeat (12) @(posedge clk_200m);   // idle gap
        if (rx_errs == errs0)
            pass_cases++;
        else
            fail_cases++;
        $display("rx case %0d kind %0d len %0d: %s", idx, kind, plen,
                 (rx_errs == errs0) ? "ok" : "mismatch");
    endtask

    always @(negedge clk_200m)
    begin : rx_monitor
        byte_t eb;
        int    ec;
        if (rstn && udp_rec_data_valid)
        begin
            if (rx_exp_byte.size() == 0)
            begin
                $display("udp_rec_data_valid high with no payload due at %0t", $time);
                rx_errs++;
            end
            else
            begin
                eb = rx_exp_byte.pop_front();
                ec = rx_exp_cyc.pop_front();
                if (udp_rec_rdata !== eb)
                begin
                    $display("error at %0t: udp_rec_rdata expected %h got %h",
                             $time, eb, udp_rec_rdata);
                    rx_errs++;
                end
                if (cyc != ec + 1)
                begin
                    $display("error at %0t: udp_rec_data_valid cycle expected %0d got %0d",
                             $time, ec + 1, cyc);
                    rx_errs++;
                end
                if (udp_rec_data_length !== rx_exp_len)
                begin
                    $display("error at %0t: udp_rec_data_length expected %0d got %0d",
                             $time, rx_exp_len, udp_rec_data_length);
                    rx_errs++;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // transmit side
    //////////////////////////////////////////////////
    task automatic send_tx(input int idx, input int len, input bit dup);
        int    n;
        int    sum;
        int    errs0;
        int    starts0;
        csum_t cs;
        errs0   = tx_errs;
        starts0 = start_cnt;
        tx_payload = {};
        for (int i = 0; i < len; i++)
            tx_payload.push_back(8'($urandom));
        put_front(T_DEST_MAC, T_LOCAL_MAC, ETH_TYPE_IPV4, len);
        build_q.push_back(IP_TTL);
        build_q.push_back(IP_PROTO_UDP);
        put_bytes(48'h0, 2);                 // csum slot, filled below
        put_bytes(48'(T_LOCAL_IP), 4);
        put_bytes(48'(T_DEST_IP), 4);
        sum = 0;
        for (int i = 22; i < 42; i += 2)
            sum = sum + int'({build_q[i], build_q[i + 1]});
        while (sum > 32'hFFFF)
            sum = (sum & 32'hFFFF) + (sum >> 16);   // end-around carry
        cs = ~csum_t'(sum);
        build_q[32] = cs[15:8];
        build_q[33] = cs[7:0];
        put_bytes(48'(T_LOCAL_PORT), 2);
        put_bytes(48'(T_DEST_PORT), 2);
        put_bytes(48'(len + 8), 2);
        put_bytes(48'h0, 2);                 // no udp csum
        foreach (tx_payload[i])
            build_q.push_back(tx_payload[i]);
        pad_and_fcs();
        tx_exp = build_q;
        tx_got = {};
        @(posedge clk_200m);
        #1;
        ram_w_end = 1'b1;
        tx_length = len_t'(len);
        @(posedge clk_200m);
        #1;
        ram_w_end = 1'b0;
        if (dup)
        begin
            n = 0;
            while (!gmii_tx_en && n < 200)
            begin
                @(negedge clk_200m);
                n++;
            end
            @(posedge clk_200m);
            #1;
            ram_w_end = 1'b1;                // should be ignored
            tx_length = len_t'(len + 5);
            @(posedge clk_200m);
            #1;
            ram_w_end = 1'b0;
        end
        n = 0;
        while (tx_got.size() < tx_exp.size() && n < 40 * frame_len(len))
        begin
            @(negedge clk_200m);
            n++;
        end
        repeat (dup ? 150 : 30) @(negedge clk_200m);   // fcs tail, ifg, stray frame
        if (tx_got.size() != tx_exp.size())
        begin
            $display("error at %0t: gmii_tx_en byte count expected %0d got %0d",
                     $time, tx_exp.size(), tx_got.size());
            tx_errs++;
        end
        for (int i = 0; i < tx_exp.size() && i < tx_got.size(); i++)
        begin
            if (tx_got[i] !== tx_exp[i])
            begin
                $display("error at %0t: gmii_txd byte %0d expected %h got %h",
                         $time, i, tx_exp[i], tx_got[i]);
                tx_errs++;
            end
        end
        if (start_cnt - starts0 != 1)
        begin
            $display("error at %0t: start_rd pulses expected 1 got %0d",
                     $time, start_cnt - starts0);
            tx_errs++;
        end
        if (tx_errs == errs0)
            pass_cases++;
        else
            fail_cases++;
        $display("tx case %0d len %0d%s: %s", idx, len, dup ? " repeat request" : "",
                 (tx_errs == errs0) ? "ok" : "mismatch");
    endtask

    always @(negedge clk_200m)
    begin
        if (rstn && gmii_tx_en)
            tx_got.push_back(gmii_txd);   // gap cycles skipped
        if (rstn && start_rd)
            start_cnt++;
    end

    // payload memory, answers start_rd after 1 to 5 cycles
    always
    begin : ram_model
        int lat;
        @(negedge clk_200m);
        if (start_rd)
        begin
            lat = $urandom_range(5, 1);
            repeat (lat) @(posedge clk_200m);
            #1;
            foreach (tx_payload[i])
            begin
                data_in_vld = 1'b1;
                rd_data     = tx_payload[i];
                @(posedge clk_200m);
                #1;
            end
            data_in_vld = 1'b0;
            rd_data     = '0;
        end
    end

    //////////////////////////////////////////////////
    // run control
    //////////////////////////////////////////////////
    initial
    begin : watchdog
        int limit;
        limit = 2000 + 40 * (frame_len(OV_RX_LEN) + frame_len(OV_TX_LEN));
        for (int i = 0; i < N_RX; i++)
            limit += 40 * frame_len(rx_len[i]);
        for (int i = 0; i < N_TX; i++)
            limit += 40 * frame_len(tx_len[i]);
        repeat (limit) @(posedge clk_200m);
        $display("watchdog expired after %0d cycles, run did not finish", limit);
        $display("Testbench failed");
        $finish;
    end

    initial
    begin : main
        void'($urandom(41518));
        rstn        = 1'b0;
        gmii_rx_dv  = 1'b0;
        gmii_rxd    = '0;
        ram_w_end   = 1'b0;
        tx_length   = '0;
        data_in_vld = 1'b0;
        rd_data     = '0;
        repeat (8) @(posedge clk_200m);
        #1;
        rstn = 1'b1;
        repeat (4) @(posedge clk_200m);
        for (int i = 0; i < N_RX; i++)
            send_rx(i, rx_kind[i], rx_len[i], rx_acc[i]);
        for (int i = 0; i < N_TX; i++)
            send_tx(i, tx_len[i], tx_dup[i]);
        fork   // rx frame overlapping a tx frame
            send_rx(N_RX, 0, OV_RX_LEN, 1'b1);
            send_tx(N_TX, OV_TX_LEN, 1'b0);
        join
        $display("%0d cases passed, %0d cases failed, %0d rx errors, %0d tx errors",
                 pass_cases, fail_cases, rx_errs, tx_errs);
        if (fail_cases == 0 && rx_errs == 0 && tx_errs == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* eth_udp_top.f */
src/eth_udp_pkg.sv
src/udp_rx_parser.sv
src/ip_hdr_checksum.sv
src/udp_tx_framer.sv
src/eth_fcs_append.sv
src/eth_udp_top.sv
verif/eth_udp_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the udp endpoint simulation with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module eth_udp_tb \
    -f eth_udp_top.f \
    -o eth_udp_sim

out=$(./obj_dir/eth_udp_sim)
echo "$out"

if echo "$out" | grep -q "Testbench passed"; then
    echo "simulation ok"
else
    echo "simulation reported a failure"
    exit 1
fi
